//--- sim.f
common/rv32i_pkg.sv
hw/agu.sv
lsq/memory_queue.sv
hw/fetch_unit.sv
hw/wb_arbiter.sv
hw/wb_sram.sv
hw/mem_subsystem.sv
tb/tb_mem_subsystem.sv

//--- tb/tb_mem_subsystem.sv
module tb_mem_subsystem;
    import rv32i_pkg::*;

    localparam int WAIT_LIMIT = 300;

    logic              clk;
    logic              rst;
    logic              enqueue_valid;
    mem_op_e           mem_op;
    logic [PREG_W-1:0] phys_reg_in;
    logic [ROB_W-1:0]  rob_tag_in;
    logic              full;
    logic [QIDX_W-1:0] mem_idx_out;
    logic              agu_valid;
    logic [31:0]       base, offset, store_data;
    logic [QIDX_W-1:0] agu_idx;
    logic              commit_valid;
    logic [ROB_W-1:0]  commit_rob;
    logic              load_valid;
    logic [PREG_W-1:0] load_preg;
    logic [31:0]       load_data;
    logic              fetch_start;
    logic [31:0]       start_pc;
    logic              instr_valid;
    logic [31:0]       instr, instr_pc;
    logic              instr_ready;

    logic [7:0]        ref_mem [MEM_WORDS*4]; // byte image of the sram
    logic [PREG_W-1:0] got_preg[$];
    logic [31:0]       got_data[$];
    logic [PREG_W-1:0] exp_preg[$];
    logic [31:0]       exp_data[$];
    logic [ROB_W-1:0]  rob_next;
    logic [QIDX_W-1:0] slot_next; // ring slot the next enqueue should get
    int                seed;

    mem_subsystem DUT (.*);

    always #4 clk = ~clk;

    // every load response, in arrival order
    always @(negedge clk) begin
        if (!rst && load_valid) begin
            got_preg.push_back(load_preg);
            got_data.push_back(load_data);
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // little endian, aligned accesses only
    function automatic void write_model(mem_op_e op, logic [31:0] a, logic [31:0] d);
        int n;
        n = (op == MEM_SB) ? 1 : (op == MEM_SH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[(a & 32'h3ff) + i] = d[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] expected_load(mem_op_e op, logic [31:0] a);
        int b;
        b = a & 32'h3ff;
        case (op)
            MEM_LB:  return {{24{ref_mem[b][7]}}, ref_mem[b]};
            MEM_LBU: return {24'h0, ref_mem[b]};
            MEM_LH:  return {{16{ref_mem[b+1][7]}}, ref_mem[b+1], ref_mem[b]};
            MEM_LHU: return {16'h0, ref_mem[b+1], ref_mem[b]};
            default: return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
        endcase
    endfunction

    task automatic enqueue(input mem_op_e op, input logic [PREG_W-1:0] preg,
                           output logic [QIDX_W-1:0] idx, output logic [ROB_W-1:0] rob);
        int n;
        @(negedge clk);
        for (n = 0; n < WAIT_LIMIT && full !== 1'b0; n++) begin
            @(negedge clk);
        end
        if (full !== 1'b0) begin
            report_timeout("full to drop");
        end else begin
            idx = mem_idx_out; // slot taken by this enqueue
            check(idx, slot_next, "mem_idx_out");
            slot_next = slot_next + 1'b1;
            @(posedge clk);
            enqueue_valid <= 1'b1;
            mem_op        <= op;
            phys_reg_in   <= preg;
            rob_tag_in    <= rob_next;
            rob      = rob_next;
            rob_next = rob_next + 1'b1;
            @(posedge clk);
            enqueue_valid <= 1'b0;
        end
    endtask

    task automatic fill_addr(input logic [QIDX_W-1:0] idx, input logic [31:0] a,
                             input logic [31:0] d);
        @(posedge clk);
        agu_valid  <= 1'b1;
        base       <= {a[31:4], 4'h0};
        offset     <= {28'h0, a[3:0]};
        store_data <= d;
        agu_idx    <= idx;
        @(posedge clk);
        agu_valid <= 1'b0;
    endtask

    // model is updated in program order, loads queue their expected result
    task automatic dispatch_op(input mem_op_e op, input logic [31:0] a, input logic [31:0] d,
                               output logic [ROB_W-1:0] rob);
        logic [PREG_W-1:0] preg;
        logic [QIDX_W-1:0] idx;
        preg = $random(seed);
        enqueue(op, preg, idx, rob);
        if (op inside {MEM_SB, MEM_SH, MEM_SW}) begin
            write_model(op, a, d);
        end else begin
            exp_preg.push_back(preg);
            exp_data.push_back(expected_load(op, a));
        end
        fill_addr(idx, a, d);
    endtask

    task automatic commit(input logic [ROB_W-1:0] rob);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_rob   <= rob;
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic wait_load(output logic [PREG_W-1:0] preg, output logic [31:0] data);
        int n;
        for (n = 0; n < WAIT_LIMIT && got_data.size() == 0; n++) begin
            @(posedge clk);
        end
        if (got_data.size() == 0) begin
            report_timeout("load_valid");
        end else begin
            preg = got_preg.pop_front();
            data = got_data.pop_front();
        end
    endtask

    task automatic check_loads();
        logic [PREG_W-1:0] p;
        logic [31:0]       d;
        while (exp_data.size() > 0) begin
            wait_load(p, d);
            check(p, exp_preg.pop_front(), "load_preg");
            check(d, exp_data.pop_front(), "load_data");
        end
        repeat (4) @(posedge clk);
        check(got_data.size(), 0, "unexpected load response");
    endtask

    task automatic pop_instr(output logic [31:0] w, output logic [31:0] pc);
        int n;
        @(negedge clk); // last pop or flush has settled here
        for (n = 0; n < WAIT_LIMIT && instr_valid !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (instr_valid !== 1'b1) begin
            report_timeout("instr_valid");
        end else begin
            w  = instr;
            pc = instr_pc;
            @(posedge clk);
            instr_ready <= 1'b1;
            @(posedge clk);
            instr_ready <= 1'b0;
        end
    endtask

    task automatic start_fetch(input logic [31:0] pc);
        @(posedge clk);
        fetch_start <= 1'b1;
        start_pc    <= pc;
        @(posedge clk);
        fetch_start <= 1'b0;
    endtask

    task automatic store_then_load();
        logic [31:0]      a;
        logic [ROB_W-1:0] rob;
        a = $random(seed) & 32'h3fc;
        dispatch_op(MEM_SW, a, $random(seed), rob);
        commit(rob);
        dispatch_op(MEM_LW, a, 0, rob);
        check_loads();
    endtask

    task automatic sub_word_access();
        logic [31:0]      a;
        logic [ROB_W-1:0] rob;
        repeat (3) begin
            a = $random(seed) & 32'h3fc;
            for (int o = 0; o < 4; o++) begin
                dispatch_op(MEM_SB, a + o, $random(seed), rob);
                commit(rob);
            end
            dispatch_op(MEM_SH, a + (($random(seed) & 1) << 1), $random(seed), rob);
            commit(rob);
            for (int o = 0; o < 4; o++) begin
                dispatch_op(MEM_LB, a + o, 0, rob);
                dispatch_op(MEM_LBU, a + o, 0, rob);
            end
            for (int o = 0; o < 4; o += 2) begin
                dispatch_op(MEM_LH, a + o, 0, rob);
                dispatch_op(MEM_LHU, a + o, 0, rob);
            end
            dispatch_op(MEM_LW, a, 0, rob);
            check_loads();
        end
    endtask

    task automatic store_waits_commit();
        logic [31:0]      a;
        logic [ROB_W-1:0] st_rob, rob;
        a = $random(seed) & 32'h3fc;
        dispatch_op(MEM_SW, a, $random(seed), st_rob);
        dispatch_op(MEM_LW, a, 0, rob);
        repeat (50) @(posedge clk);
        check(got_data.size(), 0, "load passed an uncommitted store");
        commit(st_rob);
        check_loads();
    endtask

    task automatic fill_and_drain();
        logic [QIDX_W-1:0] idx [QUEUE_DEPTH];
        logic [ROB_W-1:0]  rob [QUEUE_DEPTH];
        logic [31:0]       a   [QUEUE_DEPTH];
        logic [31:0]       d   [QUEUE_DEPTH];
        logic [PREG_W-1:0] preg;
        mem_op_e           op;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            op   = (i % 2 == 0) ? MEM_SW : MEM_LW; // each load reads back the store before it
            a[i] = (i % 2 == 0) ? ($random(seed) & 32'h3fc) : a[i-1];
            d[i] = $random(seed);
            preg = $random(seed);
            enqueue(op, preg, idx[i], rob[i]);
            if (op == MEM_SW) begin
                write_model(op, a[i], d[i]);
            end else begin
                exp_preg.push_back(preg);
                exp_data.push_back(expected_load(op, a[i]));
            end
        end
        @(negedge clk);
        check(full, 1, "full after filling the queue");
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            fill_addr(idx[i], a[i], d[i]);
            if (i % 2 == 0) commit(rob[i]);
        end
        check_loads();
        @(negedge clk);
        check(full, 0, "full after draining the queue");
    endtask

    task automatic fetch_alongside_loads();
        logic [ROB_W-1:0] rob;
        logic [31:0]      w, pc;
        for (int i = 0; i < 8; i++) begin // two code regions
            dispatch_op(MEM_SW, 32'h200 + 4*i, $random(seed), rob);
            commit(rob);
            dispatch_op(MEM_SW, 32'h280 + 4*i, $random(seed), rob);
            commit(rob);
        end
        fork
            begin
                start_fetch(32'h200);
                for (int i = 0; i < 6; i++) begin
                    pop_instr(w, pc);
                    check(pc, 32'h200 + 4*i, "instr_pc first stream");
                    check(w, expected_load(MEM_LW, 32'h200 + 4*i), "instr first stream");
                end
                start_fetch(32'h280); // restart mid-stream
                for (int i = 0; i < 8; i++) begin
                    pop_instr(w, pc);
                    check(pc, 32'h280 + 4*i, "instr_pc after restart");
                    check(w, expected_load(MEM_LW, 32'h280 + 4*i), "instr after restart");
                end
            end
            begin
                repeat (10) begin
                    dispatch_op(MEM_LW, $random(seed) & 32'h3fc, 0, rob);
                    dispatch_op(MEM_LBU, $random(seed) & 32'h3ff, 0, rob);
                end
                check_loads();
            end
        join
    endtask

    initial begin
        seed          = 32'ha79c_acc6;
        clk           = 1'b0;
        rst           = 1'b1;
        enqueue_valid = 1'b0;
        mem_op        = MEM_LW;
        phys_reg_in   = '0;
        rob_tag_in    = '0;
        agu_valid     = 1'b0;
        base          = '0;
        offset        = '0;
        store_data    = '0;
        agu_idx       = '0;
        commit_valid  = 1'b0;
        commit_rob    = '0;
        fetch_start   = 1'b0;
        start_pc      = '0;
        instr_ready   = 1'b0;
        rob_next      = '0;
        slot_next     = '0;
        for (int i = 0; i < MEM_WORDS*4; i++) ref_mem[i] = 8'h00;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        store_then_load();
        sub_word_access();
        store_waits_commit();
        fill_and_drain();
        fetch_alongside_loads();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_mem_subsystem

//--- hw/mem_subsystem.sv
module mem_subsystem (
    input  logic                         clk,
    input  logic                         rst,

    // dispatch
    input  logic                         enqueue_valid,
    input  rv32i_pkg::mem_op_e           mem_op,
    input  logic [rv32i_pkg::PREG_W-1:0] phys_reg_in,
    input  logic [rv32i_pkg::ROB_W-1:0]  rob_tag_in,
    output logic                         full,
    output logic [rv32i_pkg::QIDX_W-1:0] mem_idx_out,

    // agu operands
    input  logic                         agu_valid,
    input  logic [31:0]                  base,
    input  logic [31:0]                  offset,
    input  logic [31:0]                  store_data,
    input  logic [rv32i_pkg::QIDX_W-1:0] agu_idx,

    input  logic                         commit_valid,
    input  logic [rv32i_pkg::ROB_W-1:0]  commit_rob,

    output logic                         load_valid,
    output logic [rv32i_pkg::PREG_W-1:0] load_preg,
    output logic [31:0]                  load_data,

    // instruction side
    input  logic                         fetch_start,
    input  logic [31:0]                  start_pc,
    output logic                         instr_valid,
    output logic [31:0]                  instr,
    output logic [31:0]                  instr_pc,
    input  logic                         instr_ready
);
    import rv32i_pkg::*;

    logic              addr_valid;
    logic [31:0]       addr, wdata;
    logic [QIDX_W-1:0] mem_idx;

    logic              q_cyc, q_stb, q_we, q_ack;
    logic [31:0]       q_adr, q_dat_w, q_dat_r;
    logic [3:0]        q_sel;
    logic              f_cyc, f_stb, f_ack;
    logic [31:0]       f_adr, f_dat_r;
    logic              m_stb, m_we, m_ack;
    logic [31:0]       m_adr, m_dat_w, m_dat_r;
    logic [3:0]        m_sel;

    agu u_agu (.*);

    memory_queue u_queue (.*);

    fetch_unit u_fetch (.*);

    wb_arbiter u_arb (.*);

    wb_sram u_sram (
        .clk   (clk),
        .rst   (rst),
        .stb   (m_stb),
        .we    (m_we),
        .adr   (m_adr),
        .dat_w (m_dat_w),
        .sel   (m_sel),
        .dat_r (m_dat_r),
        .ack   (m_ack)
    );

endmodule : mem_subsystem

//--- hw/wb_sram.sv
module wb_sram (
    input  logic        clk,
    input  logic        rst,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    input  logic [3:0]  sel,
    output logic [31:0] dat_r,
    output logic        ack
);
    import rv32i_pkg::*;

    logic [31:0]          mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;
    logic                 access;

    assign idx    = adr[MEM_IDX_W+1:2]; // word address
    assign access = stb && !ack;        // new request, not the tail of the last one

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack <= access;
            if (access && we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= mem[idx];
        end
    end

endmodule : wb_sram

//--- hw/wb_arbiter.sv
module wb_arbiter (
    input  logic        clk,
    input  logic        rst,

    // memory queue master
    input  logic        q_cyc,
    input  logic        q_stb,
    input  logic        q_we,
    input  logic [31:0] q_adr,
    input  logic [31:0] q_dat_w,
    input  logic [3:0]  q_sel,
    output logic        q_ack,
    output logic [31:0] q_dat_r,

    // fetch master, read only
    input  logic        f_cyc,
    input  logic        f_stb,
    input  logic [31:0] f_adr,
    output logic        f_ack,
    output logic [31:0] f_dat_r,

    // memory slave
    output logic        m_stb,
    output logic        m_we,
    output logic [31:0] m_adr,
    output logic [31:0] m_dat_w,
    output logic [3:0]  m_sel,
    input  logic        m_ack,
    input  logic [31:0] m_dat_r
);
    import rv32i_pkg::*;

    arb_state_e state;
    logic       prio_f; // fetch wins a tie when set

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ARB_IDLE;
            prio_f <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (q_cyc && (!f_cyc || !prio_f)) state <= ARB_Q;
                    else if (f_cyc)                   state <= ARB_F;
                end
                ARB_Q: begin
                    if (!q_cyc) begin
                        state  <= ARB_IDLE;
                        prio_f <= 1'b1;
                    end
                end
                ARB_F: begin
                    if (!f_cyc) begin
                        state  <= ARB_IDLE;
                        prio_f <= 1'b0;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign m_stb   = (state == ARB_Q) ? q_stb : (state == ARB_F) && f_stb;
    assign m_we    = (state == ARB_Q) && q_we; // fetch never writes
    assign m_adr   = (state == ARB_F) ? f_adr : q_adr;
    assign m_dat_w = (state == ARB_Q) ? q_dat_w : '0;
    assign m_sel   = (state == ARB_Q) ? q_sel : 4'hf;

    assign q_ack   = (state == ARB_Q) && m_ack;
    assign f_ack   = (state == ARB_F) && m_ack;
    assign q_dat_r = (state == ARB_Q) ? m_dat_r : '0;
    assign f_dat_r = (state == ARB_F) ? m_dat_r : '0;

    // an ack belongs to the master that held the grant for the whole bus cycle
    assert property (@(posedge clk) disable iff (rst)
        m_ack |-> state != ARB_IDLE && $stable(state) && (q_ack ? q_cyc : f_cyc));

endmodule : wb_arbiter

//--- hw/fetch_unit.sv
module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_start,
    input  logic [31:0] start_pc,

    // instruction stream
    output logic        instr_valid,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    input  logic        instr_ready,

    // wishbone master
    output logic        f_cyc,
    output logic        f_stb,
    output logic [31:0] f_adr,
    input  logic [31:0] f_dat_r,
    input  logic        f_ack
);
    import rv32i_pkg::*;

    logic [FETCH_PTR_W:0] wr_ptr;
    logic [FETCH_PTR_W:0] rd_ptr;
    logic [31:0]          buf_data [FETCH_DEPTH];
    logic [31:0]          buf_pc   [FETCH_DEPTH];
    logic                 buf_full;
    logic                 active;   // set by the first fetch_start
    logic                 discard;  // outstanding reply belongs to a flushed stream
    logic [31:0]          pc;
    logic                 push;

    assign buf_full = (wr_ptr[FETCH_PTR_W-1:0] == rd_ptr[FETCH_PTR_W-1:0])
                   && (wr_ptr[FETCH_PTR_W] != rd_ptr[FETCH_PTR_W]);
    assign push        = f_cyc && f_ack && !discard && !fetch_start;
    assign f_stb       = f_cyc;
    assign instr_valid = wr_ptr != rd_ptr;
    assign instr       = buf_data[rd_ptr[FETCH_PTR_W-1:0]];
    assign instr_pc    = buf_pc[rd_ptr[FETCH_PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            active  <= 1'b0;
            discard <= 1'b0;
            f_cyc   <= 1'b0;
        end else begin
            if (f_cyc && f_ack) begin
                f_cyc   <= 1'b0;
                discard <= 1'b0;
            end else if (!f_cyc && active && !buf_full && !fetch_start) begin
                f_cyc <= 1'b1;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (instr_valid && instr_ready && !fetch_start) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (fetch_start) begin // flush, the bus cycle in flight still runs out
                active  <= 1'b1;
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                discard <= f_cyc && !f_ack;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!f_cyc) begin
            f_adr <= pc; // latched per request
        end
        if (push) begin
            buf_data[wr_ptr[FETCH_PTR_W-1:0]] <= f_dat_r;
            buf_pc[wr_ptr[FETCH_PTR_W-1:0]]   <= f_adr;
            pc                                <= pc + 32'd4;
        end
        if (fetch_start) begin
            pc <= start_pc;
        end
    end

endmodule : fetch_unit

//--- lsq/memory_queue.sv
module memory_queue (
    input  logic                         clk,
    input  logic                         rst,

    // dispatch
    input  logic                         enqueue_valid,
    input  rv32i_pkg::mem_op_e           mem_op,
    input  logic [rv32i_pkg::PREG_W-1:0] phys_reg_in,
    input  logic [rv32i_pkg::ROB_W-1:0]  rob_tag_in,

    // agu write-back
    input  logic                         addr_valid,
    input  logic [31:0]                  addr,
    input  logic [31:0]                  wdata,
    input  logic [rv32i_pkg::QIDX_W-1:0] mem_idx,

    // commit from the reorder buffer
    input  logic                         commit_valid,
    input  logic [rv32i_pkg::ROB_W-1:0]  commit_rob,

    output logic                         full,
    output logic [rv32i_pkg::QIDX_W-1:0] mem_idx_out,

    // wishbone master
    output logic                         q_cyc,
    output logic                         q_stb,
    output logic                         q_we,
    output logic [31:0]                  q_adr,
    output logic [31:0]                  q_dat_w,
    output logic [3:0]                   q_sel,
    input  logic [31:0]                  q_dat_r,
    input  logic                         q_ack,

    // load response
    output logic                         load_valid,
    output logic [rv32i_pkg::PREG_W-1:0] load_preg,
    output logic [31:0]                  load_data
);
    import rv32i_pkg::*;

    logic [QIDX_W:0]          head;  // msb is the wrap bit
    logic [QIDX_W:0]          tail;
    logic [QIDX_W-1:0]        h;

    logic [QUEUE_DEPTH-1:0]   e_valid;
    logic [QUEUE_DEPTH-1:0]   e_addr_rdy;
    logic [QUEUE_DEPTH-1:0]   e_commit;
    mem_op_e                  e_op   [QUEUE_DEPTH];
    logic [PREG_W-1:0]        e_preg [QUEUE_DEPTH];
    logic [ROB_W-1:0]         e_rob  [QUEUE_DEPTH];
    logic [31:0]              e_addr [QUEUE_DEPTH];
    logic [31:0]              e_data [QUEUE_DEPTH];

    logic                     head_ready;

    assign h           = head[QIDX_W-1:0];
    assign full        = (head[QIDX_W-1:0] == tail[QIDX_W-1:0]) && (head[QIDX_W] != tail[QIDX_W]);
    assign mem_idx_out = tail[QIDX_W-1:0];

    // stores go out only after commit
    assign head_ready = e_valid[h] && e_addr_rdy[h] && (!is_store(e_op[h]) || e_commit[h]);

    // bus fields come straight from the head slot, which holds still until ack
    assign q_stb = q_cyc;
    assign q_we  = is_store(e_op[h]);
    assign q_adr = e_addr[h];
    assign q_sel = byte_sel(e_op[h], e_addr[h][1:0]);

    always_comb begin
        case (e_op[h])
            MEM_SB:  q_dat_w = {4{e_data[h][7:0]}};  // every lane, sel picks one
            MEM_SH:  q_dat_w = {2{e_data[h][15:0]}};
            default: q_dat_w = e_data[h];
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            e_valid    <= '0;
            e_addr_rdy <= '0;
            e_commit   <= '0;
            q_cyc      <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            if (q_cyc && q_ack) begin // retire
                q_cyc      <= 1'b0;
                e_valid[h] <= 1'b0;
                head       <= head + 1'b1;
                load_valid <= !is_store(e_op[h]);
            end else if (!q_cyc && head_ready) begin
                q_cyc <= 1'b1;
            end

            if (enqueue_valid && !full) begin
                e_valid[tail[QIDX_W-1:0]]    <= 1'b1;
                e_addr_rdy[tail[QIDX_W-1:0]] <= 1'b0;
                e_commit[tail[QIDX_W-1:0]]   <= 1'b0;
                tail                         <= tail + 1'b1;
            end

            if (addr_valid) begin
                e_addr_rdy[mem_idx] <= 1'b1;
            end

            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (commit_valid && e_valid[i] && e_rob[i] == commit_rob) begin
                    e_commit[i] <= 1'b1;
                end
            end
        end
    end

    // entry payload and load result
    always_ff @(posedge clk) begin
        if (enqueue_valid && !full) begin
            e_op[tail[QIDX_W-1:0]]   <= mem_op;
            e_preg[tail[QIDX_W-1:0]] <= phys_reg_in;
            e_rob[tail[QIDX_W-1:0]]  <= rob_tag_in;
        end
        if (addr_valid) begin
            e_addr[mem_idx] <= addr;
            e_data[mem_idx] <= wdata;
        end
        if (q_cyc && q_ack) begin
            load_preg <= e_preg[h];
            load_data <= load_extend(e_op[h], e_addr[h][1:0], q_dat_r);
        end
    end

    assert property (@(posedge clk) disable iff (rst) enqueue_valid |-> !full);

    // agu result must target a slot that dispatch already filled
    assert property (@(posedge clk) disable iff (rst) addr_valid |-> e_valid[mem_idx]);

    assert property (@(posedge clk) disable iff (rst)
        q_stb && !q_ack |=> q_stb && $stable(q_adr) && $stable(q_we) && $stable(q_sel));

endmodule : memory_queue

//--- hw/agu.sv
module agu (
    input  logic                         clk,
    input  logic                         rst,

    // operands from dispatch
    input  logic                         agu_valid,
    input  logic [31:0]                  base,
    input  logic [31:0]                  offset,
    input  logic [31:0]                  store_data,
    input  logic [rv32i_pkg::QIDX_W-1:0] agu_idx,

    // result towards the memory queue
    output logic                         addr_valid,
    output logic [31:0]                  addr,
    output logic [31:0]                  wdata,
    output logic [rv32i_pkg::QIDX_W-1:0] mem_idx
);
    logic [31:0] sum;

    assign sum = base + offset; // no alignment check, accesses assumed aligned

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= agu_valid;
        end
    end

    // payload follows the valid bit, no reset
    always_ff @(posedge clk) begin
        if (agu_valid) begin
            addr    <= sum;
            wdata   <= store_data;
            mem_idx <= agu_idx; // tags the slot to fill
        end
    end

endmodule : agu

//--- common/rv32i_pkg.sv
package rv32i_pkg;

    localparam int QUEUE_DEPTH = 8;
    localparam int QIDX_W      = $clog2(QUEUE_DEPTH);
    localparam int PREG_W      = 6;
    localparam int ROB_W       = 6;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int FETCH_DEPTH = 4;
    localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);

    typedef enum logic [2:0] {
        MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {ARB_IDLE, ARB_Q, ARB_F} arb_state_e;

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    // lane enables for the wishbone sel lines
    function automatic logic [3:0] byte_sel(mem_op_e op, logic [1:0] a);
        case (op)
            MEM_SB, MEM_LB, MEM_LBU: return 4'b0001 << a;
            MEM_SH, MEM_LH, MEM_LHU: return a[1] ? 4'b1100 : 4'b0011;
            default:                 return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] load_extend(mem_op_e op, logic [1:0] a, logic [31:0] w);
        logic [31:0] sh;
        sh = w >> {a, 3'b000}; // selected byte or half lands in the low bits
        case (op)
            MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
            MEM_LBU: return {24'b0, sh[7:0]};
            MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
            MEM_LHU: return {16'b0, sh[15:0]};
            default: return w;
        endcase
    endfunction

endpackage : rv32i_pkg
